// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_datapath
RTL_TOP   ?= datapath
FILELIST  ?= datapath.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --timescale $(TIMESCALE) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the outcome, the simulator exit code does not
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: datapath.f
source/datapath_cfg_pkg.sv
source/alu_ops_pkg.sv
source/delay_line.sv
source/io_predication.sv
source/data_memory.sv
source/alu.sv
source/datapath.sv
test/tb_clock_gen.sv
test/tb_datapath.sv

// File: source/alu.sv
// Two-operand ALU with carry and overflow, registered and piped to write-back
module alu
    import datapath_cfg_pkg::*, alu_ops_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  alu_ctrl_t  ctrl,
    input  word_t      operand_a,
    input  word_t      operand_b,
    output word_t      result,
    output alu_flags_t flags
);

    // First stage computes, the rest line up with the write-back stage
    localparam int PIPE_DEPTH = 4;

    logic [WORD_WIDTH:0] sum;
    logic [WORD_WIDTH:0] diff;
    logic                sign_a;
    logic                sign_b;
    word_t               result_next;
    alu_flags_t          flags_next;

    assign sum    = {1'b0, operand_a} + {1'b0, operand_b};
    assign diff   = {1'b0, operand_a} - {1'b0, operand_b};
    assign sign_a = operand_a[WORD_WIDTH-1];
    assign sign_b = operand_b[WORD_WIDTH-1];

    always_comb begin
        result_next = operand_a;
        flags_next  = '0;
        case (ctrl.op)
            op_add: begin
                result_next         = sum[WORD_WIDTH-1:0];
                flags_next.carry    = sum[WORD_WIDTH];
                // Same signs in, other sign out
                flags_next.overflow = (sign_a == sign_b) && (sum[WORD_WIDTH-1] != sign_a);
            end
            op_sub: begin
                result_next         = diff[WORD_WIDTH-1:0];
                flags_next.carry    = diff[WORD_WIDTH];
                flags_next.overflow = (sign_a != sign_b) && (diff[WORD_WIDTH-1] != sign_a);
            end
            op_and:    result_next = operand_a & operand_b;
            op_or:     result_next = operand_a | operand_b;
            op_xor:    result_next = operand_a ^ operand_b;
            op_pass_a: result_next = operand_a;
            default:   result_next = operand_a;
        endcase
    end

    // ------------------------------
    // Output pipeline
    // ------------------------------

    word_t      result_pipe [PIPE_DEPTH];
    alu_flags_t flags_pipe  [PIPE_DEPTH];

    always_ff @(posedge clk) begin
        result_pipe[0] <= result_next;
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            result_pipe[i] <= result_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                flags_pipe[i] <= '0;
            end
        end else begin
            flags_pipe[0] <= flags_next;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                flags_pipe[i] <= flags_pipe[i-1];
            end
        end
    end

    assign result = result_pipe[PIPE_DEPTH-1];
    assign flags  = flags_pipe[PIPE_DEPTH-1];

endmodule

// File: source/alu_ops_pkg.sv
// ALU operation encoding, control struct and flag struct
package alu_ops_pkg;

    localparam int ALU_OP_WIDTH = 3;

    typedef enum logic [ALU_OP_WIDTH-1:0] {
        op_add    = 3'd0,
        op_sub    = 3'd1,
        op_and    = 3'd2,
        op_or     = 3'd3,
        op_xor    = 3'd4,
        op_pass_a = 3'd5
    } alu_op_t;

    // --------------------------------
    // Control word of one instruction
    // --------------------------------

    typedef struct packed {
        alu_op_t op;
        // Write the result through write address A
        logic    wr_a;
        // Write the result through write address B
        logic    wr_b;
    } alu_ctrl_t;

    // Carry is also the borrow of a subtract
    typedef struct packed {
        logic carry;
        logic overflow;
    } alu_flags_t;

endpackage

// File: source/data_memory.sv
// Data memories A and B, I/O read selection, write-back and I/O write enables
module data_memory
    import datapath_cfg_pkg::*;
#(
    parameter int unsigned IO_PORT_BASE_ADDR = 1016
) (
    input  logic       clk,
    input  logic       arst_n,
    input  addr_t      read_addr_a,
    input  addr_t      read_addr_b,
    input  logic       rd_is_io_a,
    input  logic       rd_is_io_b,
    input  port_idx_t  rd_port_a,
    input  port_idx_t  rd_port_b,
    input  word_t      io_read_data_a [IO_PORT_COUNT],
    input  word_t      io_read_data_b [IO_PORT_COUNT],
    input  addr_t      wr_addr_a,
    input  addr_t      wr_addr_b,
    input  logic       wr_en_a,
    input  logic       wr_en_b,
    input  word_t      wr_data,
    output word_t      operand_a,
    output word_t      operand_b,
    output port_mask_t io_wren_a,
    output port_mask_t io_wren_b
);

    word_t mem_a [MEM_DEPTH];
    word_t mem_b [MEM_DEPTH];

    // ------------------------------
    // Read path
    // ------------------------------

    word_t ram_data_a;
    word_t ram_data_b;
    word_t io_data_a;
    word_t io_data_b;
    logic  s3_is_io_a;
    logic  s3_is_io_b;

    // Stage 3, array read and I/O capture during the read pulse
    always_ff @(posedge clk) begin
        ram_data_a <= mem_a[read_addr_a];
        ram_data_b <= mem_b[read_addr_b];
        io_data_a  <= io_read_data_a[rd_port_a];
        io_data_b  <= io_read_data_b[rd_port_b];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s3_is_io_a <= 1'b0;
            s3_is_io_b <= 1'b0;
        end else begin
            s3_is_io_a <= rd_is_io_a;
            s3_is_io_b <= rd_is_io_b;
        end
    end

    // Stage 4, operand select
    always_ff @(posedge clk) begin
        operand_a <= s3_is_io_a ? io_data_a : ram_data_a;
        operand_b <= s3_is_io_b ? io_data_b : ram_data_b;
    end

    // ------------------------------
    // Write-back
    // ------------------------------

    logic wr_io_a;
    logic wr_io_b;

    assign wr_io_a = io_window_hit(wr_addr_a, IO_PORT_BASE_ADDR);
    assign wr_io_b = io_window_hit(wr_addr_b, IO_PORT_BASE_ADDR);

    // Window addresses go out as port strobes instead of array writes
    assign io_wren_a = (wr_en_a && wr_io_a)
                     ? io_port_mask(io_port_index(wr_addr_a, IO_PORT_BASE_ADDR)) : '0;
    assign io_wren_b = (wr_en_b && wr_io_b)
                     ? io_port_mask(io_port_index(wr_addr_b, IO_PORT_BASE_ADDR)) : '0;

    always_ff @(posedge clk) begin
        if (wr_en_a && !wr_io_a) begin
            mem_a[wr_addr_a] <= wr_data;
        end
        if (wr_en_b && !wr_io_b) begin
            mem_b[wr_addr_b] <= wr_data;
        end
    end

    a_io_wren_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(io_wren_a) && $onehot0(io_wren_b)
    );

endmodule

// File: source/datapath.sv
// Datapath top level with predication, delay lines, data memories and ALU
module datapath
    import datapath_cfg_pkg::*, alu_ops_pkg::*;
#(
    parameter int unsigned IO_PORT_BASE_ADDR = 1016
) (
    input  logic          clk,
    input  logic          arst_n,
    input  alu_ctrl_t     ctrl,
    input  operand_addr_t addr,
    input  logic          cancel,
    input  io_status_t    io_status,
    input  word_t         io_read_data_a [IO_PORT_COUNT],
    input  word_t         io_read_data_b [IO_PORT_COUNT],
    output port_mask_t    io_rden_a,
    output port_mask_t    io_rden_b,
    output logic          io_ready,
    output port_mask_t    io_wren_a,
    output port_mask_t    io_wren_b,
    output word_t         io_write_data,
    output word_t         result,
    output alu_flags_t    flags,
    output logic          wren_a,
    output logic          wren_b,
    output addr_t         write_addr_a,
    output addr_t         write_addr_b
);

    typedef struct packed {
        alu_ctrl_t     ctrl;
        operand_addr_t addr;
    } dl1_t;

    typedef struct packed {
        alu_ctrl_t ctrl;
        addr_t     write_a;
        addr_t     write_b;
        logic      annul;
    } dl2_t;

    typedef struct packed {
        addr_t write_a;
        addr_t write_b;
        logic  en_a;
        logic  en_b;
    } dl3_t;

    dl1_t      dl1_in, dl1_out;
    dl2_t      dl2_in, dl2_out;
    dl3_t      dl3_in, dl3_out;
    logic      rd_is_io_a, rd_is_io_b;
    port_idx_t rd_port_a, rd_port_b;
    logic      annul;
    word_t     operand_a, operand_b;

    // ------------------------------
    // Stages 1 and 2
    // ------------------------------

    io_predication #(.IO_PORT_BASE_ADDR(IO_PORT_BASE_ADDR)) u_io_predication (
        .clk(clk), .arst_n(arst_n), .addr(addr), .ctrl(ctrl), .cancel(cancel),
        .io_status(io_status), .io_rden_a(io_rden_a), .io_rden_b(io_rden_b),
        .rd_is_io_a(rd_is_io_a), .rd_is_io_b(rd_is_io_b),
        .rd_port_a(rd_port_a), .rd_port_b(rd_port_b),
        .io_ready(io_ready), .annul(annul)
    );

    assign dl1_in = '{ctrl: ctrl, addr: addr};

    delay_line #(.DEPTH(2), .WIDTH($bits(dl1_t))) u_dl_predication (
        .clk(clk), .arst_n(arst_n), .in(dl1_in), .out(dl1_out)
    );

    // ------------------------------
    // Stages 3 and 4
    // ------------------------------

    assign dl2_in = '{ctrl: dl1_out.ctrl, write_a: dl1_out.addr.write_a,
                      write_b: dl1_out.addr.write_b, annul: annul};

    delay_line #(.DEPTH(2), .WIDTH($bits(dl2_t))) u_dl_memory (
        .clk(clk), .arst_n(arst_n), .in(dl2_in), .out(dl2_out)
    );

    data_memory #(.IO_PORT_BASE_ADDR(IO_PORT_BASE_ADDR)) u_data_memory (
        .clk(clk), .arst_n(arst_n),
        .read_addr_a(dl1_out.addr.read_a), .read_addr_b(dl1_out.addr.read_b),
        .rd_is_io_a(rd_is_io_a), .rd_is_io_b(rd_is_io_b),
        .rd_port_a(rd_port_a), .rd_port_b(rd_port_b),
        .io_read_data_a(io_read_data_a), .io_read_data_b(io_read_data_b),
        .wr_addr_a(write_addr_a), .wr_addr_b(write_addr_b),
        .wr_en_a(wren_a), .wr_en_b(wren_b), .wr_data(result),
        .operand_a(operand_a), .operand_b(operand_b),
        .io_wren_a(io_wren_a), .io_wren_b(io_wren_b)
    );

    // ------------------------------
    // Stages 5 to 8
    // ------------------------------

    // Annulled instructions still compute but never write back
    assign dl3_in = '{write_a: dl2_out.write_a, write_b: dl2_out.write_b,
                      en_a: dl2_out.ctrl.wr_a && !dl2_out.annul,
                      en_b: dl2_out.ctrl.wr_b && !dl2_out.annul};

    delay_line #(.DEPTH(4), .WIDTH($bits(dl3_t))) u_dl_alu (
        .clk(clk), .arst_n(arst_n), .in(dl3_in), .out(dl3_out)
    );

    alu u_alu (
        .clk(clk), .arst_n(arst_n), .ctrl(dl2_out.ctrl),
        .operand_a(operand_a), .operand_b(operand_b),
        .result(result), .flags(flags)
    );

    assign write_addr_a  = dl3_out.write_a;
    assign write_addr_b  = dl3_out.write_b;
    assign wren_a        = dl3_out.en_a;
    assign wren_b        = dl3_out.en_b;
    assign io_write_data = result;

endmodule

// File: source/datapath_cfg_pkg.sv
// Datapath widths, word and address types, operand address and I/O status structs, window helpers
package datapath_cfg_pkg;

    localparam int WORD_WIDTH       = 36;
    localparam int ADDR_WIDTH       = 10;
    localparam int MEM_DEPTH        = 1024;
    localparam int IO_PORT_COUNT    = 4;
    localparam int PORT_INDEX_WIDTH = $clog2(IO_PORT_COUNT);

    typedef logic [WORD_WIDTH-1:0]       word_t;
    typedef logic [ADDR_WIDTH-1:0]       addr_t;
    typedef logic [IO_PORT_COUNT-1:0]    port_mask_t;
    typedef logic [PORT_INDEX_WIDTH-1:0] port_idx_t;

    // Operand addresses of one instruction
    typedef struct packed {
        addr_t read_a;
        addr_t read_b;
        addr_t write_a;
        addr_t write_b;
    } operand_addr_t;

    // EF is 1 when a read port holds data or a write port has room
    typedef struct packed {
        port_mask_t read_ef_a;
        port_mask_t read_ef_b;
        port_mask_t write_ef_a;
        port_mask_t write_ef_b;
    } io_status_t;

    // True when the address falls in the I/O port window
    function automatic logic io_window_hit(addr_t addr, int unsigned base);
        return (32'(addr) >= base) && (32'(addr) < base + IO_PORT_COUNT);
    endfunction

    function automatic port_idx_t io_port_index(addr_t addr, int unsigned base);
        return port_idx_t'(addr - addr_t'(base));
    endfunction

    function automatic port_mask_t io_port_mask(port_idx_t idx);
        return port_mask_t'(1) << idx;
    endfunction

endpackage

// File: source/delay_line.sv
// Register chain of configurable depth and width, cleared by reset
module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    generate
        if (DEPTH == 0) begin : g_wire
            assign out = in;
        end else begin : g_regs
            logic [WIDTH-1:0] stages [DEPTH];

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stages[i] <= '0;
                    end
                end else begin
                    stages[0] <= in;
                    for (int i = 1; i < DEPTH; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            assign out = stages[DEPTH-1];
        end
    endgenerate

    a_width_positive: assert property (@(posedge clk) WIDTH > 0);

endmodule

// File: source/io_predication.sv
// I/O window decoding, empty/full predication, io_ready, annul and read pulses
module io_predication
    import datapath_cfg_pkg::*, alu_ops_pkg::*;
#(
    parameter int unsigned IO_PORT_BASE_ADDR = 1016
) (
    input  logic          clk,
    input  logic          arst_n,
    input  operand_addr_t addr,
    input  alu_ctrl_t     ctrl,
    input  logic          cancel,
    input  io_status_t    io_status,
    output port_mask_t    io_rden_a,
    output port_mask_t    io_rden_b,
    output logic          rd_is_io_a,
    output logic          rd_is_io_b,
    output port_idx_t     rd_port_a,
    output port_idx_t     rd_port_b,
    output logic          io_ready,
    output logic          annul
);

    // ------------------------------
    // Stage 1 decode
    // ------------------------------

    logic      hit_rd_a;
    logic      hit_rd_b;
    logic      hit_wr_a;
    logic      hit_wr_b;
    port_idx_t idx_rd_a;
    port_idx_t idx_rd_b;
    port_idx_t idx_wr_a;
    port_idx_t idx_wr_b;
    logic      blocked;

    assign hit_rd_a = io_window_hit(addr.read_a, IO_PORT_BASE_ADDR);
    assign hit_rd_b = io_window_hit(addr.read_b, IO_PORT_BASE_ADDR);
    assign hit_wr_a = io_window_hit(addr.write_a, IO_PORT_BASE_ADDR);
    assign hit_wr_b = io_window_hit(addr.write_b, IO_PORT_BASE_ADDR);

    assign idx_rd_a = io_port_index(addr.read_a, IO_PORT_BASE_ADDR);
    assign idx_rd_b = io_port_index(addr.read_b, IO_PORT_BASE_ADDR);
    assign idx_wr_a = io_port_index(addr.write_a, IO_PORT_BASE_ADDR);
    assign idx_wr_b = io_port_index(addr.write_b, IO_PORT_BASE_ADDR);

    // Any empty read port or full write port blocks the instruction
    assign blocked = (hit_rd_a && !io_status.read_ef_a[idx_rd_a])
                  || (hit_rd_b && !io_status.read_ef_b[idx_rd_b])
                  || (ctrl.wr_a && hit_wr_a && !io_status.write_ef_a[idx_wr_a])
                  || (ctrl.wr_b && hit_wr_b && !io_status.write_ef_b[idx_wr_b]);

    logic      s1_rd_is_io_a;
    logic      s1_rd_is_io_b;
    port_idx_t s1_rd_port_a;
    port_idx_t s1_rd_port_b;
    logic      s1_blocked;
    logic      s1_cancel;
    logic      s1_annul;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_rd_is_io_a <= 1'b0;
            s1_rd_is_io_b <= 1'b0;
            s1_rd_port_a  <= '0;
            s1_rd_port_b  <= '0;
            s1_blocked    <= 1'b1;
            s1_cancel     <= 1'b0;
        end else begin
            s1_rd_is_io_a <= hit_rd_a;
            s1_rd_is_io_b <= hit_rd_b;
            s1_rd_port_a  <= idx_rd_a;
            s1_rd_port_b  <= idx_rd_b;
            s1_blocked    <= blocked;
            s1_cancel     <= cancel;
        end
    end

    assign s1_annul = s1_blocked || s1_cancel;

    // ------------------------------
    // Stage 2 outputs
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            io_ready   <= 1'b0;
            annul      <= 1'b1;
            io_rden_a  <= '0;
            io_rden_b  <= '0;
            rd_is_io_a <= 1'b0;
            rd_is_io_b <= 1'b0;
            rd_port_a  <= '0;
            rd_port_b  <= '0;
        end else begin
            io_ready   <= !s1_blocked;
            annul      <= s1_annul;
            // Pop a port only when the instruction really executes
            io_rden_a  <= (s1_rd_is_io_a && !s1_annul) ? io_port_mask(s1_rd_port_a) : '0;
            io_rden_b  <= (s1_rd_is_io_b && !s1_annul) ? io_port_mask(s1_rd_port_b) : '0;
            rd_is_io_a <= s1_rd_is_io_a;
            rd_is_io_b <= s1_rd_is_io_b;
            rd_port_a  <= s1_rd_port_a;
            rd_port_b  <= s1_rd_port_b;
        end
    end

    // A pulse traces back to a ready, uncancelled instruction with data in that port
    a_rden_needs_ready: assert property (
        @(posedge clk) disable iff (!arst_n)
        (|io_rden_a || |io_rden_b) |->
            io_ready && !$past(cancel, 2)
            && ((io_rden_a & ~$past(io_status.read_ef_a, 2)) == '0)
            && ((io_rden_b & ~$past(io_status.read_ef_b, 2)) == '0)
    );

endmodule

// File: test/tb_clock_gen.sv
// Testbench clock source and active-low reset generator
module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: test/tb_datapath.sv
// Datapath testbench with memory model, ALU reference, directed tests and final report
module tb_datapath
    import datapath_cfg_pkg::*, alu_ops_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     IO_BASE       = 1016;
    localparam int     LATENCY       = 8;
    localparam int     RDEN_TIMEOUT  = 6;
    localparam int     RESET_TIMEOUT = 40;
    localparam longint SIGNED_MAX    = (longint'(1) << (WORD_WIDTH - 1)) - 1;
    localparam longint SIGNED_MIN    = -(longint'(1) << (WORD_WIDTH - 1));

    logic          clk;
    logic          arst_n;
    alu_ctrl_t     ctrl;
    operand_addr_t addr;
    logic          cancel;
    io_status_t    io_status;
    word_t         io_read_data_a [IO_PORT_COUNT];
    word_t         io_read_data_b [IO_PORT_COUNT];
    port_mask_t    io_rden_a;
    port_mask_t    io_rden_b;
    logic          io_ready;
    port_mask_t    io_wren_a;
    port_mask_t    io_wren_b;
    word_t         io_write_data;
    word_t         result;
    alu_flags_t    flags;
    logic          wren_a;
    logic          wren_b;
    addr_t         write_addr_a;
    addr_t         write_addr_b;

    // Software copy of both data memories
    word_t  mem_a_model [MEM_DEPTH];
    word_t  mem_b_model [MEM_DEPTH];
    integer seed = 32'hca38;
    int     since_issue = 0;
    int     checks = 0;
    int     errors = 0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(10)) u_clock_gen (
        .clk(clk), .arst_n(arst_n)
    );

    datapath #(.IO_PORT_BASE_ADDR(IO_BASE)) u_datapath (
        .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .addr(addr), .cancel(cancel),
        .io_status(io_status),
        .io_read_data_a(io_read_data_a), .io_read_data_b(io_read_data_b),
        .io_rden_a(io_rden_a), .io_rden_b(io_rden_b), .io_ready(io_ready),
        .io_wren_a(io_wren_a), .io_wren_b(io_wren_b), .io_write_data(io_write_data),
        .result(result), .flags(flags), .wren_a(wren_a), .wren_b(wren_b),
        .write_addr_a(write_addr_a), .write_addr_b(write_addr_b)
    );

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    function automatic word_t rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[WORD_WIDTH-1:0];
    endfunction

    function automatic alu_ctrl_t ctrl_word(alu_op_t op, logic wa, logic wb);
        return '{op: op, wr_a: wa, wr_b: wb};
    endfunction

    function automatic operand_addr_t operand_addrs(int ra, int rb, int wa, int wb);
        return '{read_a: addr_t'(ra), read_b: addr_t'(rb),
                 write_a: addr_t'(wa), write_b: addr_t'(wb)};
    endfunction

    // Reference ALU, signed range taken from 64-bit arithmetic
    function automatic word_t alu_model(alu_op_t op, word_t a, word_t b,
                                        output alu_flags_t f);
        longint unsigned sum_wide;
        longint          sa;
        longint          sb;
        longint          exact;
        word_t           r;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        f  = '0;
        case (op)
            op_add: begin
                sum_wide   = 64'(a) + 64'(b);
                r          = sum_wide[WORD_WIDTH-1:0];
                f.carry    = sum_wide[WORD_WIDTH];
                exact      = sa + sb;
                f.overflow = (exact > SIGNED_MAX) || (exact < SIGNED_MIN);
            end
            op_sub: begin
                r          = a - b;
                f.carry    = (a < b);
                exact      = sa - sb;
                f.overflow = (exact > SIGNED_MAX) || (exact < SIGNED_MIN);
            end
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            default: r = a;
        endcase
        return r;
    endfunction

    task automatic drive_nop();
        ctrl   = ctrl_word(op_pass_a, 1'b0, 1'b0);
        addr   = '0;
        cancel = 1'b0;
    endtask

    task automatic step();
        @(negedge clk);
        since_issue++;
    endtask

    // One instruction for one cycle, then idle slots
    task automatic issue(alu_ctrl_t c, operand_addr_t a, logic cx);
        ctrl        = c;
        addr        = a;
        cancel      = cx;
        since_issue = 0;
        step();
        drive_nop();
    endtask

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Bounded by n, optionally watching for stray read pulses
    task automatic advance_to(int n, logic quiet);
        while (since_issue < n) begin
            if (quiet) begin
                check_val("io_rden_a", 64'(io_rden_a), 64'd0);
                check_val("io_rden_b", 64'(io_rden_b), 64'd0);
            end
            step();
        end
    endtask

    task automatic wait_rden();
        int waited;
        waited = 0;
        while (!(|io_rden_a || |io_rden_b) && waited < RDEN_TIMEOUT) begin
            step();
            waited++;
        end
        if (!(|io_rden_a || |io_rden_b)) begin
            errors++;
            $display("Timeout: no io_rden pulse within %0d cycles", waited);
        end
    endtask

    task automatic run_instr(alu_ctrl_t c, operand_addr_t a, logic cx);
        issue(c, a, cx);
        advance_to(LATENCY, 1'b0);
    endtask

    task automatic check_writeback(word_t exp_res, alu_flags_t exp_flags,
                                   logic en_a, logic en_b, int wa, int wb);
        check_val("result", 64'(result), 64'(exp_res));
        check_val("flags", 64'(flags), 64'(exp_flags));
        check_val("wren_a", 64'(wren_a), 64'(en_a));
        check_val("wren_b", 64'(wren_b), 64'(en_b));
        if (en_a) begin
            check_val("write_addr_a", 64'(write_addr_a), 64'(addr_t'(wa)));
        end
        if (en_b) begin
            check_val("write_addr_b", 64'(write_addr_b), 64'(addr_t'(wb)));
        end
    endtask

    // Port word copied into both memories at dst
    task automatic load_word(int dst, int port, word_t w);
        io_read_data_a[port] = w;
        run_instr(ctrl_word(op_pass_a, 1'b1, 1'b1),
                  operand_addrs(IO_BASE + port, 0, dst, dst), 1'b0);
        check_writeback(w, '0, 1'b1, 1'b1, dst, dst);
        mem_a_model[dst] = w;
        mem_b_model[dst] = w;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic reset_values();
        int waited;
        waited = 0;
        while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            errors++;
            $display("Timeout: reset was never released");
        end
        check_val("io_ready", 64'(io_ready), 64'd0);
        check_val("io_rden_a", 64'(io_rden_a), 64'd0);
        check_val("io_rden_b", 64'(io_rden_b), 64'd0);
        check_val("io_wren_a", 64'(io_wren_a), 64'd0);
        check_val("io_wren_b", 64'(io_wren_b), 64'd0);
        check_val("wren_a", 64'(wren_a), 64'd0);
        check_val("wren_b", 64'(wren_b), 64'd0);
    endtask

    task automatic alu_operations();
        alu_op_t    op_list [6] = '{op_add, op_sub, op_and, op_or, op_xor, op_pass_a};
        int         src_a [3] = '{10, 12, 12};
        int         src_b [3] = '{11, 13, 12};
        int         dst;
        word_t      exp_res;
        alu_flags_t exp_flags;
        load_word(10, 0, rand_word());
        load_word(11, 1, rand_word());
        // Largest positive and a negative word to hit carry and overflow
        load_word(12, 2, 36'h7_ffff_ffff);
        load_word(13, 3, 36'h8_0000_0001);
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 6; k++) begin
                dst     = 50 + 6 * p + k;
                exp_res = alu_model(op_list[k], mem_a_model[src_a[p]],
                                    mem_b_model[src_b[p]], exp_flags);
                run_instr(ctrl_word(op_list[k], 1'b1, 1'b0),
                          operand_addrs(src_a[p], src_b[p], dst, 0), 1'b0);
                check_writeback(exp_res, exp_flags, 1'b1, 1'b0, dst, 0);
                mem_a_model[dst] = exp_res;
            end
        end
    endtask

    task automatic write_then_read();
        word_t w;
        w = rand_word();
        load_word(20, 0, w);
        // Issued in the cycle the write lands
        run_instr(ctrl_word(op_or, 1'b0, 1'b0), operand_addrs(20, 20, 0, 0), 1'b0);
        check_writeback(w, '0, 1'b0, 1'b0, 0, 0);
    endtask

    task automatic io_port_reads();
        word_t      exp_res;
        alu_flags_t exp_flags;
        for (int p = 0; p < IO_PORT_COUNT; p++) begin
            io_read_data_a[p] = rand_word();
            io_read_data_b[p] = rand_word();
        end
        exp_res = alu_model(op_xor, io_read_data_a[2], io_read_data_b[1], exp_flags);
        issue(ctrl_word(op_xor, 1'b0, 1'b0),
              operand_addrs(IO_BASE + 2, IO_BASE + 1, 0, 0), 1'b0);
        wait_rden();
        check_val("io_rden_latency", 64'(since_issue), 64'd2);
        check_val("io_rden_a", 64'(io_rden_a), 64'(1) << 2);
        check_val("io_rden_b", 64'(io_rden_b), 64'(1) << 1);
        check_val("io_ready", 64'(io_ready), 64'd1);
        // The pulse lasts a single cycle
        step();
        advance_to(LATENCY, 1'b1);
        check_writeback(exp_res, exp_flags, 1'b0, 1'b0, 0, 0);

        // Empty port 3 on side A
        io_status.read_ef_a[3] = 1'b0;
        issue(ctrl_word(op_pass_a, 1'b1, 1'b0), operand_addrs(IO_BASE + 3, 10, 40, 0), 1'b0);
        advance_to(2, 1'b1);
        check_val("io_ready", 64'(io_ready), 64'd0);
        advance_to(LATENCY, 1'b1);
        check_val("wren_a", 64'(wren_a), 64'd0);
        check_val("wren_b", 64'(wren_b), 64'd0);
        io_status.read_ef_a[3] = 1'b1;
    endtask

    task automatic io_port_writes();
        word_t exp_res;
        exp_res = mem_a_model[10];
        run_instr(ctrl_word(op_pass_a, 1'b1, 1'b1),
                  operand_addrs(10, 11, IO_BASE + 1, IO_BASE + 3), 1'b0);
        check_writeback(exp_res, '0, 1'b1, 1'b1, IO_BASE + 1, IO_BASE + 3);
        check_val("io_wren_a", 64'(io_wren_a), 64'(1) << 1);
        check_val("io_wren_b", 64'(io_wren_b), 64'(1) << 3);
        check_val("io_write_data", 64'(io_write_data), 64'(exp_res));
        step();
        check_val("io_wren_a", 64'(io_wren_a), 64'd0);
        check_val("io_wren_b", 64'(io_wren_b), 64'd0);

        // Full port 3 on side B annuls both writes
        io_status.write_ef_b[3] = 1'b0;
        issue(ctrl_word(op_pass_a, 1'b1, 1'b1),
              operand_addrs(10, 11, IO_BASE + 1, IO_BASE + 3), 1'b0);
        advance_to(2, 1'b0);
        check_val("io_ready", 64'(io_ready), 64'd0);
        advance_to(LATENCY, 1'b0);
        check_val("io_wren_a", 64'(io_wren_a), 64'd0);
        check_val("io_wren_b", 64'(io_wren_b), 64'd0);
        check_val("wren_a", 64'(wren_a), 64'd0);
        check_val("wren_b", 64'(wren_b), 64'd0);
        io_status.write_ef_b[3] = 1'b1;
    endtask

    task automatic cancel_and_stream();
        word_t      exp_res [8];
        alu_flags_t exp_flags [8];
        alu_flags_t fl;
        word_t      r;
        int         src_a;
        int         src_b;
        issue(ctrl_word(op_pass_a, 1'b1, 1'b1), operand_addrs(11, 11, 10, 10), 1'b1);
        advance_to(2, 1'b0);
        // Cancel leaves io_ready alone
        check_val("io_ready", 64'(io_ready), 64'd1);
        advance_to(LATENCY, 1'b0);
        check_val("wren_a", 64'(wren_a), 64'd0);
        check_val("wren_b", 64'(wren_b), 64'd0);
        run_instr(ctrl_word(op_pass_a, 1'b0, 1'b0), operand_addrs(10, 10, 0, 0), 1'b0);
        check_writeback(mem_a_model[10], '0, 1'b0, 1'b0, 0, 0);
        r = alu_model(op_xor, mem_a_model[10], mem_b_model[10], fl);
        run_instr(ctrl_word(op_xor, 1'b0, 1'b0), operand_addrs(10, 10, 0, 0), 1'b0);
        check_writeback(r, fl, 1'b0, 1'b0, 0, 0);

        // Eight in flight, one issued per cycle
        for (int c = 0; c < 2 * LATENCY; c++) begin
            if (c < LATENCY) begin
                src_a      = 10 + c % 4;
                src_b      = 10 + (c + 1) % 4;
                exp_res[c] = alu_model(alu_op_t'(c % 6), mem_a_model[src_a],
                                       mem_b_model[src_b], exp_flags[c]);
                ctrl       = ctrl_word(alu_op_t'(c % 6), 1'b1, 1'b0);
                addr       = operand_addrs(src_a, src_b, 100 + c, 0);
            end else begin
                drive_nop();
                check_writeback(exp_res[c - LATENCY], exp_flags[c - LATENCY],
                                1'b1, 1'b0, 100 + c - LATENCY, 0);
                mem_a_model[100 + c - LATENCY] = exp_res[c - LATENCY];
            end
            step();
        end
    endtask

    // ------------------------------
    // Sequence and report
    // ------------------------------

    initial begin
        drive_nop();
        io_status = '1;
        for (int p = 0; p < IO_PORT_COUNT; p++) begin
            io_read_data_a[p] = '0;
            io_read_data_b[p] = '0;
        end
        reset_values();
        alu_operations();
        write_then_read();
        io_port_reads();
        io_port_writes();
        cancel_and_stream();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
